// File: verilog/start_screen_cfg.svh
// ---------------------------------------------------------------------------
// Screen geometry and colours for the start screen pipeline.
// Counts are for a 1024x768 visible area; counters must hold the full
// frame including blanking, hence 11 bits.
// ---------------------------------------------------------------------------

`ifndef START_SCREEN_CFG_SVH
`define START_SCREEN_CFG_SVH

// Visible area
`define SS_H_ACTIVE 1024
`define SS_V_ACTIVE 768

// Scan counter width
`define SS_CNT_W 11

// 4 bits per channel
`define SS_RGB_W 12

// Palette
`define SS_FRAME_COLOR   12'hF_F_F
`define SS_PLAYER1_COLOR 12'hF_8_0

// Table length of 33 title, 4 button outline and 18 label entries
`define SS_RECT_COUNT 55

// Table index range of the button outline
`define SS_OUTLINE_FIRST 33
`define SS_OUTLINE_LAST  36

// Exclusive row bounds of the title glyphs
`define SS_TITLE_V_LO 60
`define SS_TITLE_V_HI 140

`endif

// File: verilog/start_screen_pkg.sv
// ---------------------------------------------------------------------------
// Types shared by the start screen stages and the rectangle table.
// Table order is priority order; a rectangle covers lo < count < hi
// on both axes, so its edge rows and columns are not drawn.
// ---------------------------------------------------------------------------

`default_nettype none

`include "start_screen_cfg.svh"

package start_screen_pkg;

    typedef enum logic [1:0] {
        CLASS_BLACK   = 2'd0,
        CLASS_FRAME   = 2'd1,
        CLASS_PLAYER1 = 2'd2
    } colour_class_t;

    // Raw VGA timing as it arrives from the timing generator
    typedef struct packed {
        logic [`SS_CNT_W-1:0] vcount;
        logic                 vsync;
        logic                 vblnk;
        logic [`SS_CNT_W-1:0] hcount;
        logic                 hsync;
        logic                 hblnk;
    } scan_t;

    typedef struct packed {
        scan_t                scan;
        logic [`SS_RGB_W-1:0] rgb;
    } vga_out_t;

    typedef struct packed {
        scan_t scan;
        logic  active;
        logic  border;
    } capt_t;

    typedef struct packed {
        scan_t         scan;
        logic          active;
        logic          border;
        colour_class_t cls;
    } match_t;

    typedef struct packed {
        logic [`SS_CNT_W-1:0] v_lo;
        logic [`SS_CNT_W-1:0] v_hi;
        logic [`SS_CNT_W-1:0] h_lo;
        logic [`SS_CNT_W-1:0] h_hi;
        colour_class_t        cls;
    } rect_t;

    localparam rect_t RECT_TABLE [`SS_RECT_COUNT] = '{
        // LINE
        '{11'd60,  11'd140, 11'd302, 11'd312, CLASS_PLAYER1},
        '{11'd130, 11'd140, 11'd302, 11'd342, CLASS_PLAYER1},
        '{11'd60,  11'd140, 11'd352, 11'd362, CLASS_PLAYER1},
        '{11'd60,  11'd140, 11'd372, 11'd382, CLASS_PLAYER1},
        '{11'd60,  11'd140, 11'd412, 11'd422, CLASS_PLAYER1},
        '{11'd76,  11'd92,  11'd382, 11'd392, CLASS_PLAYER1},
        '{11'd92,  11'd108, 11'd392, 11'd402, CLASS_PLAYER1},
        '{11'd108, 11'd124, 11'd402, 11'd412, CLASS_PLAYER1},
        '{11'd60,  11'd140, 11'd432, 11'd442, CLASS_PLAYER1},
        '{11'd60,  11'd70,  11'd432, 11'd472, CLASS_PLAYER1},
        '{11'd130, 11'd140, 11'd432, 11'd472, CLASS_PLAYER1},
        '{11'd95,  11'd105, 11'd432, 11'd462, CLASS_PLAYER1},
        // RUSH
        '{11'd60,  11'd140, 11'd522, 11'd532, CLASS_PLAYER1},
        '{11'd60,  11'd70,  11'd522, 11'd542, CLASS_PLAYER1},
        '{11'd70,  11'd80,  11'd542, 11'd552, CLASS_PLAYER1},
        '{11'd80,  11'd100, 11'd552, 11'd562, CLASS_PLAYER1},
        '{11'd100, 11'd110, 11'd542, 11'd552, CLASS_PLAYER1},
        '{11'd110, 11'd120, 11'd522, 11'd542, CLASS_PLAYER1},
        '{11'd120, 11'd130, 11'd542, 11'd552, CLASS_PLAYER1},
        '{11'd130, 11'd140, 11'd552, 11'd562, CLASS_PLAYER1},
        '{11'd60,  11'd130, 11'd572, 11'd582, CLASS_PLAYER1},
        '{11'd130, 11'd140, 11'd582, 11'd612, CLASS_PLAYER1},
        '{11'd60,  11'd130, 11'd612, 11'd622, CLASS_PLAYER1},
        '{11'd60,  11'd70,  11'd642, 11'd662, CLASS_PLAYER1},
        '{11'd70,  11'd90,  11'd632, 11'd642, CLASS_PLAYER1},
        '{11'd70,  11'd80,  11'd662, 11'd672, CLASS_PLAYER1},
        '{11'd90,  11'd100, 11'd642, 11'd662, CLASS_PLAYER1},
        '{11'd100, 11'd130, 11'd662, 11'd672, CLASS_PLAYER1},
        '{11'd130, 11'd140, 11'd642, 11'd662, CLASS_PLAYER1},
        '{11'd120, 11'd130, 11'd632, 11'd642, CLASS_PLAYER1},
        '{11'd60,  11'd140, 11'd682, 11'd692, CLASS_PLAYER1},
        '{11'd60,  11'd140, 11'd712, 11'd722, CLASS_PLAYER1},
        '{11'd95,  11'd105, 11'd682, 11'd722, CLASS_PLAYER1},
        // Button outline
        '{11'd330, 11'd335, 11'd282, 11'd742, CLASS_FRAME},
        '{11'd330, 11'd450, 11'd282, 11'd287, CLASS_FRAME},
        '{11'd330, 11'd450, 11'd737, 11'd742, CLASS_FRAME},
        '{11'd445, 11'd450, 11'd282, 11'd742, CLASS_FRAME},
        // PLAY label
        '{11'd350, 11'd430, 11'd422, 11'd432, CLASS_PLAYER1},
        '{11'd350, 11'd360, 11'd422, 11'd442, CLASS_PLAYER1},
        '{11'd360, 11'd370, 11'd442, 11'd452, CLASS_PLAYER1},
        '{11'd370, 11'd390, 11'd452, 11'd462, CLASS_PLAYER1},
        '{11'd390, 11'd400, 11'd442, 11'd452, CLASS_PLAYER1},
        '{11'd400, 11'd410, 11'd422, 11'd442, CLASS_PLAYER1},
        '{11'd410, 11'd430, 11'd422, 11'd432, CLASS_PLAYER1},
        '{11'd350, 11'd430, 11'd472, 11'd482, CLASS_PLAYER1},
        '{11'd420, 11'd430, 11'd472, 11'd512, CLASS_PLAYER1},
        '{11'd360, 11'd430, 11'd522, 11'd532, CLASS_PLAYER1},
        '{11'd360, 11'd430, 11'd552, 11'd562, CLASS_PLAYER1},
        '{11'd350, 11'd360, 11'd532, 11'd552, CLASS_PLAYER1},
        '{11'd380, 11'd390, 11'd522, 11'd562, CLASS_PLAYER1},
        '{11'd350, 11'd370, 11'd572, 11'd582, CLASS_PLAYER1},
        '{11'd370, 11'd380, 11'd582, 11'd592, CLASS_PLAYER1},
        '{11'd380, 11'd430, 11'd592, 11'd602, CLASS_PLAYER1},
        '{11'd370, 11'd380, 11'd602, 11'd612, CLASS_PLAYER1},
        '{11'd350, 11'd370, 11'd612, 11'd622, CLASS_PLAYER1}
    };

endpackage

`default_nettype wire

// File: verilog/scan_capture.sv
// ---------------------------------------------------------------------------
// First pipeline stage, one cycle. Expects counts that start at zero on
// the first visible pixel of each line and frame.
// ---------------------------------------------------------------------------

`default_nettype none

`include "start_screen_cfg.svh"

module scan_capture (
    input  logic                    clk,
    input  logic                    rst,
    input  start_screen_pkg::scan_t scan,
    output start_screen_pkg::capt_t capt
);

    localparam logic [`SS_CNT_W-1:0] H_ACTIVE = `SS_CNT_W'(`SS_H_ACTIVE);
    localparam logic [`SS_CNT_W-1:0] H_LAST   = `SS_CNT_W'(`SS_H_ACTIVE - 1);
    localparam logic [`SS_CNT_W-1:0] V_LAST   = `SS_CNT_W'(`SS_V_ACTIVE - 1);

    logic active_nxt;
    logic edge_pix;

    assign active_nxt = !scan.hblnk && !scan.vblnk;

    // Outermost ring of the visible area
    assign edge_pix = (scan.vcount == '0) || (scan.vcount == V_LAST) ||
                      (scan.hcount == '0) || (scan.hcount == H_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            capt <= '0;
        end else begin
            capt.scan   <= scan;
            capt.active <= active_nxt;
            capt.border <= active_nxt && edge_pix;
        end
    end

    // Timing generator must raise hblnk before the count leaves the screen
    hcount_in_range: assert property (
        @(posedge clk) disable iff (rst)
        !scan.hblnk |-> (scan.hcount < H_ACTIVE)
    ) else $error("hcount %0d outside visible width with hblnk low", scan.hcount);

endmodule

`default_nettype wire

// File: verilog/glyph_matcher.sv
// ---------------------------------------------------------------------------
// Second pipeline stage, one cycle. All table rectangles are compared
// in parallel; the lowest index that hits sets the colour class.
// ---------------------------------------------------------------------------

`default_nettype none

`include "start_screen_cfg.svh"

module glyph_matcher (
    input  logic                     clk,
    input  logic                     rst,
    input  start_screen_pkg::capt_t  capt,
    output start_screen_pkg::match_t match
);

    localparam int IDX_W = $clog2(`SS_RECT_COUNT);

    logic [`SS_RECT_COUNT-1:0]        hit_vec;
    logic [IDX_W-1:0]                 hit_idx;
    start_screen_pkg::colour_class_t  cls_nxt;
    logic                             in_title;

    always_comb begin
        for (int i = 0; i < `SS_RECT_COUNT; i++) begin
            hit_vec[i] = (start_screen_pkg::RECT_TABLE[i].v_lo < capt.scan.vcount) &&
                         (capt.scan.vcount < start_screen_pkg::RECT_TABLE[i].v_hi) &&
                         (start_screen_pkg::RECT_TABLE[i].h_lo < capt.scan.hcount) &&
                         (capt.scan.hcount < start_screen_pkg::RECT_TABLE[i].h_hi);
        end
    end

    // Walk from the back so the lowest index is written last
    always_comb begin
        cls_nxt = start_screen_pkg::CLASS_BLACK;
        hit_idx = '0;
        for (int i = `SS_RECT_COUNT - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                cls_nxt = start_screen_pkg::RECT_TABLE[i].cls;
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign in_title = (capt.scan.vcount > `SS_CNT_W'(`SS_TITLE_V_LO)) &&
                      (capt.scan.vcount < `SS_CNT_W'(`SS_TITLE_V_HI));

    always_ff @(posedge clk) begin
        if (rst) begin
            match <= '0;
        end else begin
            match.scan   <= capt.scan;
            match.active <= capt.active;
            match.border <= capt.border;
            match.cls    <= cls_nxt;
        end
    end

    // Title glyphs are player-one only; frame colour there must come
    // from the button outline entries
    title_not_frame: assert property (
        @(posedge clk) disable iff (rst)
        (in_title && cls_nxt == start_screen_pkg::CLASS_FRAME) |->
            (hit_idx >= IDX_W'(`SS_OUTLINE_FIRST) && hit_idx <= IDX_W'(`SS_OUTLINE_LAST))
    ) else $error("frame class from entry %0d in title rows", hit_idx);

endmodule

`default_nettype wire

// File: verilog/pixel_output.sv
// ---------------------------------------------------------------------------
// Last pipeline stage, one cycle. Blanking forces black, then the
// screen border, then the class colour from the matcher.
// ---------------------------------------------------------------------------

`default_nettype none

`include "start_screen_cfg.svh"

module pixel_output (
    input  logic                       clk,
    input  logic                       rst,
    input  start_screen_pkg::match_t   match,
    output start_screen_pkg::vga_out_t vga_out
);

    logic [`SS_RGB_W-1:0] rgb_nxt;

    always_comb begin
        if (!match.active) begin
            rgb_nxt = '0;
        end else if (match.border) begin
            rgb_nxt = `SS_FRAME_COLOR;
        end else begin
            case (match.cls)
                start_screen_pkg::CLASS_FRAME:   rgb_nxt = `SS_FRAME_COLOR;
                start_screen_pkg::CLASS_PLAYER1: rgb_nxt = `SS_PLAYER1_COLOR;
                default:                         rgb_nxt = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out.scan <= match.scan;
            vga_out.rgb  <= rgb_nxt;
        end
    end

    // Active flag was derived two stages back, so blanking and colour
    // must still agree at the pins
    black_in_blank: assert property (
        @(posedge clk) disable iff (rst)
        (vga_out.scan.hblnk || vga_out.scan.vblnk) |-> (vga_out.rgb == '0)
    ) else $error("rgb %h driven during blanking", vga_out.rgb);

endmodule

`default_nettype wire

// File: verilog/start_screen.sv
// ---------------------------------------------------------------------------
// Start screen overlay. Fixed three cycle latency from scan to vga_out,
// one pixel accepted every clock, no stall.
// ---------------------------------------------------------------------------

`default_nettype none

module start_screen (
    input  logic                       clk,
    input  logic                       rst,
    input  start_screen_pkg::scan_t    scan,
    output start_screen_pkg::vga_out_t vga_out
);

    start_screen_pkg::capt_t  capt;
    start_screen_pkg::match_t match;

    scan_capture scan_capture_i (
        .clk  (clk),
        .rst  (rst),
        .scan (scan),
        .capt (capt)
    );

    glyph_matcher glyph_matcher_i (
        .clk   (clk),
        .rst   (rst),
        .capt  (capt),
        .match (match)
    );

    pixel_output pixel_output_i (
        .clk     (clk),
        .rst     (rst),
        .match   (match),
        .vga_out (vga_out)
    );

endmodule

`default_nettype wire

// File: bench/start_screen_tb.sv
// ---------------------------------------------------------------------------
// Random scan stimulus checked against a reference model of the screen.
// Stimulus keeps hcount inside the visible width while hblnk is low.
// Outputs are sampled on the falling edge, two rising edges after capture.
// ---------------------------------------------------------------------------

`default_nettype none

`include "start_screen_cfg.svh"

module start_screen_tb;

    localparam int STREAM_LEN = 4000;
    localparam int MAX_CYCLES = 20000;
    localparam int LATENCY    = 3;
    localparam int OUT_W      = $bits(start_screen_pkg::vga_out_t);

    logic                       clk;
    logic                       rst;
    start_screen_pkg::scan_t    scan;
    start_screen_pkg::vga_out_t vga_out;

    // Expected outputs for the samples in flight
    start_screen_pkg::vga_out_t exp_q [$];

    start_screen start_screen_i (
        .clk     (clk),
        .rst     (rst),
        .scan    (scan),
        .vga_out (vga_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        for (int n = 0; n < MAX_CYCLES; n++) begin
            @(posedge clk);
        end
        $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
        $display("*** FAILED ***");
        $fatal(1);
    end

    task automatic check_value(input logic [OUT_W-1:0] got, input logic [OUT_W-1:0] exp,
                               input string what);
        start_screen_pkg::vga_out_t e;
        e = exp;
        if (got !== exp) begin
            $display("[ERROR] %0t: %s at v=%0d h=%0d, got %h expected %h", $time, what,
                     e.scan.vcount, e.scan.hcount, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    function automatic logic [`SS_RGB_W-1:0] class_colour(start_screen_pkg::colour_class_t c);
        case (c)
            start_screen_pkg::CLASS_FRAME:   return `SS_FRAME_COLOR;
            start_screen_pkg::CLASS_PLAYER1: return `SS_PLAYER1_COLOR;
            default:                         return '0;
        endcase
    endfunction

    // Reference screen in priority order of blanking, border and first table hit
    function automatic start_screen_pkg::vga_out_t model_pixel(start_screen_pkg::scan_t s);
        start_screen_pkg::vga_out_t o;
        start_screen_pkg::rect_t    r;
        logic                       active;
        logic                       on_edge;
        logic                       found;
        int                         v;
        int                         h;
        o.scan  = s;
        o.rgb   = '0;
        v       = int'(s.vcount);
        h       = int'(s.hcount);
        active  = !s.hblnk && !s.vblnk;
        on_edge = (v == 0) || (v == `SS_V_ACTIVE - 1) || (h == 0) || (h == `SS_H_ACTIVE - 1);
        found   = 1'b0;
        if (active && on_edge) begin
            o.rgb = `SS_FRAME_COLOR;
        end else if (active) begin
            for (int i = 0; i < `SS_RECT_COUNT; i++) begin
                r = start_screen_pkg::RECT_TABLE[i];
                if (!found && int'(r.v_lo) < v && v < int'(r.v_hi) &&
                    int'(r.h_lo) < h && h < int'(r.h_hi)) begin
                    o.rgb = class_colour(r.cls);
                    found = 1'b1;
                end
            end
        end
        return o;
    endfunction

    function automatic logic [`SS_CNT_W-1:0] rand_count(input int lo, input int hi);
        return `SS_CNT_W'($urandom_range(hi, lo));
    endfunction

    function automatic start_screen_pkg::scan_t active_scan(input int v, input int h);
        start_screen_pkg::scan_t s;
        s.vcount = `SS_CNT_W'(v);
        s.hcount = `SS_CNT_W'(h);
        s.vsync  = 1'($urandom_range(1, 0));
        s.hsync  = 1'($urandom_range(1, 0));
        s.vblnk  = 1'b0;
        s.hblnk  = 1'b0;
        return s;
    endfunction

    function automatic start_screen_pkg::scan_t blank_scan();
        start_screen_pkg::scan_t s;
        int                      kind;
        kind     = $urandom_range(2, 0);
        s        = active_scan(0, 0);
        s.hblnk  = (kind != 1);
        s.vblnk  = (kind != 0);
        s.vcount = rand_count(0, 2047);
        // hcount may run past the screen only inside horizontal blanking
        s.hcount = s.hblnk ? rand_count(0, 2047) : rand_count(0, `SS_H_ACTIVE - 1);
        return s;
    endfunction

    function automatic start_screen_pkg::scan_t border_scan();
        int side;
        int v;
        int h;
        side = $urandom_range(3, 0);
        v    = $urandom_range(`SS_V_ACTIVE - 1, 0);
        h    = $urandom_range(`SS_H_ACTIVE - 1, 0);
        case (side)
            0:       v = 0;
            1:       v = `SS_V_ACTIVE - 1;
            2:       h = 0;
            default: h = `SS_H_ACTIVE - 1;
        endcase
        return active_scan(v, h);
    endfunction

    // Lands on, just inside or just outside a rectangle edge
    function automatic int near_edge(input int lo, input int hi);
        case ($urandom_range(5, 0))
            0:       return lo - 1;
            1:       return lo;
            2:       return lo + 1;
            3:       return hi - 1;
            4:       return hi;
            default: return $urandom_range(hi + 1, lo - 1);
        endcase
    endfunction

    function automatic start_screen_pkg::scan_t band_scan();
        start_screen_pkg::rect_t r;
        int                      idx;
        idx = $urandom_range(`SS_RECT_COUNT - 1, 0);
        r   = start_screen_pkg::RECT_TABLE[idx];
        return active_scan(near_edge(int'(r.v_lo), int'(r.v_hi)),
                           near_edge(int'(r.h_lo), int'(r.h_hi)));
    endfunction

    function automatic start_screen_pkg::scan_t background_scan();
        return active_scan($urandom_range(`SS_V_ACTIVE - 1, 0),
                           $urandom_range(`SS_H_ACTIVE - 1, 0));
    endfunction

    function automatic start_screen_pkg::scan_t mixed_scan();
        case ($urandom_range(7, 0))
            0, 1:    return blank_scan();
            2:       return border_scan();
            3, 4, 5: return band_scan();
            default: return background_scan();
        endcase
    endfunction

    // Record what the DUT captures on this clock, drive the next sample
    // and compare the output on the falling edge
    task automatic step(input start_screen_pkg::scan_t next_scan, input logic next_rst);
        start_screen_pkg::vga_out_t exp;
        logic                       rst_seen;
        @(posedge clk);
        rst_seen = rst;
        if (rst_seen) begin
            // Reset clears every stage at once
            foreach (exp_q[i]) begin
                exp_q[i] = '0;
            end
            exp_q.push_back('0);
        end else begin
            exp_q.push_back(model_pixel(scan));
        end
        scan <= next_scan;
        rst  <= next_rst;
        @(negedge clk);
        if (exp_q.size() == LATENCY) begin
            exp = exp_q.pop_front();
            check_value(vga_out, exp, "pipeline output");
        end else if (rst_seen) begin
            check_value(vga_out, '0, "output in reset");
        end
    endtask

    initial begin
        rst  = 1'b1;
        scan = '0;
        void'($urandom(61240));

        // Traffic during reset must not reach the output
        for (int i = 0; i < 5; i++) begin
            step(mixed_scan(), i < 4);
        end
        for (int i = 0; i < 200; i++) begin
            step(blank_scan(), 1'b0);
        end
        for (int i = 0; i < 200; i++) begin
            step(border_scan(), 1'b0);
        end
        for (int i = 0; i < 600; i++) begin
            step(band_scan(), 1'b0);
        end
        for (int i = 0; i < 300; i++) begin
            step(background_scan(), 1'b0);
        end
        for (int i = 0; i < STREAM_LEN; i++) begin
            step(mixed_scan(), 1'b0);
        end
        // Push the last samples out of the pipeline
        for (int i = 0; i < LATENCY; i++) begin
            step(blank_scan(), 1'b0);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: start_screen.f
+incdir+verilog
verilog/start_screen_pkg.sv
verilog/scan_capture.sv
verilog/glyph_matcher.sv
verilog/pixel_output.sv
verilog/start_screen.sv
bench/start_screen_tb.sv

// File: Makefile
# Verilator build and run of the start screen testbench

BIN  := obj_dir/Vstart_screen_tb
SRCS := $(filter-out +%,$(shell cat start_screen.f)) verilog/start_screen_cfg.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes
$(BIN): start_screen.f $(SRCS)
	verilator --binary --timing --assert -j 0 \
		--top-module start_screen_tb -f start_screen.f \
		-o Vstart_screen_tb

# Pass or fail comes from the log, not from the simulator status
run: $(BIN)
	./$(BIN) 2>&1 | tee sim.log
	grep -qx '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
